/* csr_cfg_config.svh */
// CSR index config stage widths, sequence length and FIFO depth
`ifndef CSR_CFG_CONFIG_SVH
`define CSR_CFG_CONFIG_SVH

// --------------------
// Response word
// --------------------
`define CSR_DATA_W      32
`define CSR_OFFSET_W    16

// Words per configuration sequence, only the first ones carry fields
`define CSR_SEQ_LEN     16
`define CSR_FIELD_WORDS 8

// Granularity and shift amount
`define CSR_GRAN_W      5

// --------------------
// Route and location fields
// --------------------
`define CSR_CMD_W       3
`define CSR_MODULE_W    2
`define CSR_ENGINE_W    2
`define CSR_CHANNEL_W   2
`define CSR_CU_W        2
`define CSR_BUNDLE_W    2
`define CSR_LANE_W      2
`define CSR_BUFFER_W    3

// Unused upper bits of the route and location words
`define CSR_ROUTE_PAD_W (`CSR_DATA_W-`CSR_CMD_W-`CSR_MODULE_W-`CSR_ENGINE_W-`CSR_CHANNEL_W)
`define CSR_PLACE_PAD_W (`CSR_DATA_W-`CSR_CU_W-`CSR_BUNDLE_W-`CSR_LANE_W-`CSR_BUFFER_W)

// Finished packets held while the consumer stalls
`define CSR_FIFO_DEPTH  4

`endif

/* csr_cfg_pkg.sv */
// CSR index config types: response word, typed word, word views and packet
`default_nettype none
`include "csr_cfg_config.svh"

package csr_cfg_pkg;

    // Memory command codes, every value of the field is named
    typedef enum logic [`CSR_CMD_W-1:0] {
        CMD_MEM_INVALID   = 3'd0,
        CMD_MEM_READ      = 3'd1,
        CMD_MEM_WRITE     = 3'd2,
        CMD_MEM_FLUSH     = 3'd3,
        CMD_MEM_CONFIGURE = 3'd4,
        CMD_ENGINE        = 3'd5,
        CMD_CONTROL       = 3'd6,
        CMD_RESERVED      = 3'd7
    } cmd_e;

    typedef struct packed {
        logic                     valid;
        logic [`CSR_OFFSET_W-1:0] offset;
        logic [`CSR_DATA_W-1:0]   data;
    } mem_resp_t;

    // --------------------
    // Views of one data word
    // --------------------
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        struct packed {
            logic [`CSR_DATA_W-6:0] reserved;
            logic                   mode_break;
            logic                   mode_buffer;
            logic                   mode_sequence;
            logic                   decrement;
            logic                   increment;
        } mode_view;
        struct packed {
            logic                              direction;
            logic [`CSR_DATA_W-`CSR_GRAN_W-2:0] reserved;
            logic [`CSR_GRAN_W-1:0]            granularity;
        } range_view;
        struct packed {
            logic [`CSR_ROUTE_PAD_W-1:0] reserved;
            logic [`CSR_CHANNEL_W-1:0]   id_channel;
            logic [`CSR_ENGINE_W-1:0]    id_engine;
            logic [`CSR_MODULE_W-1:0]    id_module;
            cmd_e                        cmd;
        } route_view;
        struct packed {
            logic [`CSR_PLACE_PAD_W-1:0] reserved;
            logic [`CSR_BUFFER_W-1:0]    id_buffer;
            logic [`CSR_LANE_W-1:0]      id_lane;
            logic [`CSR_BUNDLE_W-1:0]    id_bundle;
            logic [`CSR_CU_W-1:0]        id_cu;
        } place_view;
    } cfg_word_u;

    // Word handed from decode to execute
    typedef struct packed {
        logic                                valid;
        logic [$clog2(`CSR_FIELD_WORDS)-1:0] index;
        logic                                last;
        cfg_word_u                           data;
    } typed_word_t;

    // Index configuration packet
    typedef struct packed {
        logic                      increment;
        logic                      decrement;
        logic                      mode_sequence;
        logic                      mode_buffer;
        logic                      mode_break;
        logic [`CSR_DATA_W-1:0]    index_start;
        logic [`CSR_DATA_W-1:0]    index_end;
        logic [`CSR_DATA_W-1:0]    stride;
        logic [`CSR_GRAN_W-1:0]    granularity;
        logic                      direction;
        logic [`CSR_GRAN_W-1:0]    shift_amount;
        logic                      shift_direction;
        cmd_e                      cmd;
        logic [`CSR_MODULE_W-1:0]  id_module;
        logic [`CSR_ENGINE_W-1:0]  id_engine;
        logic [`CSR_CHANNEL_W-1:0] id_channel;
        logic [`CSR_CU_W-1:0]      id_cu;
        logic [`CSR_BUNDLE_W-1:0]  id_bundle;
        logic [`CSR_LANE_W-1:0]    id_lane;
        logic [`CSR_BUFFER_W-1:0]  id_buffer;
        logic [`CSR_DATA_W-1:0]    array_size;
    } csr_cfg_t;

endpackage : csr_cfg_pkg

`default_nettype wire

/* csr_cfg_decode.sv */
// CSR config decode: filters the offset window, tracks the sequence and types the words
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg_config.svh"

module csr_cfg_decode #(
    parameter int seq_base = 0
) (
    input  wire                      ap_clk,
    input  wire                      areset_csr_index_generator,
    input  wire csr_cfg_pkg::mem_resp_t resp_in,
    output csr_cfg_pkg::typed_word_t word
);

    localparam int cnt_w = $clog2(`CSR_SEQ_LEN);
    localparam int idx_w = $clog2(`CSR_FIELD_WORDS);

    // Window bounds one bit wider than the offset so the top bound cannot wrap
    localparam logic [`CSR_OFFSET_W:0] win_lo = (`CSR_OFFSET_W+1)'(seq_base);
    localparam logic [`CSR_OFFSET_W:0] win_hi = (`CSR_OFFSET_W+1)'(seq_base + `CSR_SEQ_LEN);

    localparam logic [cnt_w-1:0] last_pos    = cnt_w'(`CSR_SEQ_LEN - 1);
    localparam logic [cnt_w-1:0] field_words = cnt_w'(`CSR_FIELD_WORDS);

    csr_cfg_pkg::mem_resp_t resp_reg;
    logic [`CSR_OFFSET_W:0] offset_ext;
    logic                   in_window;
    logic                   at_start;
    logic                   accept;
    logic                   emit;
    logic                   seq_active;
    logic [cnt_w-1:0]       seq_count;
    logic [cnt_w-1:0]       position;

    // --------------------
    // Input register
    // --------------------
    always_ff @(posedge ap_clk) begin
        resp_reg <= resp_in;
        if (areset_csr_index_generator) begin
            resp_reg.valid <= 1'b0;
        end
    end

    // Window check and position of the current word
    always_comb begin
        offset_ext = {1'b0, resp_reg.offset};
        in_window  = (offset_ext >= win_lo) && (offset_ext < win_hi);
        accept     = resp_reg.valid && in_window;
        at_start   = (offset_ext == win_lo) && !seq_active;
        // Once started, words count by arrival and their offset no longer matters
        emit       = accept && (seq_active || at_start);
        position   = seq_active ? seq_count : '0;
    end

    // --------------------
    // Sequence tracker
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seq_active <= 1'b0;
            seq_count  <= '0;
        end else if (emit) begin
            if (position == last_pos) begin
                seq_active <= 1'b0;
                seq_count  <= '0;
            end else begin
                seq_active <= 1'b1;
                seq_count  <= position + 1'b1;
            end
        end
    end

    // Typed word, valid only for the field words, last on the final word
    always_ff @(posedge ap_clk) begin
        word.valid <= emit && (position < field_words);
        word.index <= position[idx_w-1:0];
        word.last  <= emit && (position == last_pos);
        word.data  <= resp_reg.data;
        if (areset_csr_index_generator) begin
            word.valid <= 1'b0;
            word.last  <= 1'b0;
        end
    end

endmodule : csr_cfg_decode

`default_nettype wire

/* csr_cfg_execute.sv */
// CSR config execute: builds the index configuration packet from the typed words
`timescale 1ns/100ps
`default_nettype none

module csr_cfg_execute (
    input  wire                         ap_clk,
    input  wire                         areset_csr_index_generator,
    input  wire csr_cfg_pkg::typed_word_t word,
    output csr_cfg_pkg::csr_cfg_t       pkt,
    output logic                        pkt_valid
);

    // Packet is complete one cycle after the last word
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= word.last;
        end
    end

    // --------------------
    // Field assembly
    // --------------------
    // Fields keep their values until a later word rewrites them
    always_ff @(posedge ap_clk) begin
        if (word.valid) begin
            case (word.index)
                3'd0: begin
                    pkt.increment     <= word.data.mode_view.increment;
                    pkt.decrement     <= word.data.mode_view.decrement;
                    pkt.mode_sequence <= word.data.mode_view.mode_sequence;
                    pkt.mode_buffer   <= word.data.mode_view.mode_buffer;
                    pkt.mode_break    <= word.data.mode_view.mode_break;
                end
                3'd1: begin
                    pkt.index_start <= word.data.raw;
                end
                3'd2: begin
                    pkt.index_end <= word.data.raw;
                end
                3'd3: begin
                    pkt.stride <= word.data.raw;
                end
                3'd4: begin
                    pkt.granularity     <= word.data.range_view.granularity;
                    pkt.direction       <= word.data.range_view.direction;
                    // Address shift follows the granularity
                    pkt.shift_amount    <= word.data.range_view.granularity;
                    pkt.shift_direction <= word.data.range_view.direction;
                end
                3'd5: begin
                    pkt.cmd        <= word.data.route_view.cmd;
                    pkt.id_module  <= word.data.route_view.id_module;
                    pkt.id_engine  <= word.data.route_view.id_engine;
                    pkt.id_channel <= word.data.route_view.id_channel;
                end
                3'd6: begin
                    pkt.id_cu     <= word.data.place_view.id_cu;
                    pkt.id_bundle <= word.data.place_view.id_bundle;
                    pkt.id_lane   <= word.data.place_view.id_lane;
                    pkt.id_buffer <= word.data.place_view.id_buffer;
                end
                3'd7: begin
                    pkt.array_size <= word.data.raw;
                end
            endcase
        end
    end

endmodule : csr_cfg_execute

`default_nettype wire

/* csr_cfg_result.sv */
// CSR config result: FIFO of finished packets popped with a valid/ready pair
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg_config.svh"

module csr_cfg_result (
    input  wire                      ap_clk,
    input  wire                      areset_csr_index_generator,
    input  wire csr_cfg_pkg::csr_cfg_t pkt,
    input  wire                      pkt_valid,
    output csr_cfg_pkg::csr_cfg_t    cfg_out,
    output logic                     cfg_valid,
    input  wire                      cfg_ready
);

    localparam int ptr_w = $clog2(`CSR_FIFO_DEPTH);
    localparam int cnt_w = $clog2(`CSR_FIFO_DEPTH + 1);

    localparam logic [ptr_w-1:0] last_slot = ptr_w'(`CSR_FIFO_DEPTH - 1);
    localparam logic [cnt_w-1:0] depth     = cnt_w'(`CSR_FIFO_DEPTH);

    csr_cfg_pkg::csr_cfg_t mem [`CSR_FIFO_DEPTH];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign full      = (count == depth);
    assign push      = pkt_valid && !full;
    assign cfg_valid = (count != '0);
    assign pop       = cfg_valid && cfg_ready;
    assign cfg_out   = mem[rd_ptr];

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt;
        end
    end

    // Pointers wrap at the last slot, the count tracks occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : csr_cfg_result

`default_nettype wire

/* csr_cfg_top.sv */
// CSR index generator config stage: decode, packet assembly and output FIFO
`timescale 1ns/100ps
`default_nettype none

module csr_cfg_top #(
    parameter int seq_base = 0
) (
    input  wire                         ap_clk,
    input  wire                         areset_csr_index_generator,
    input  wire csr_cfg_pkg::mem_resp_t resp_in,
    output csr_cfg_pkg::csr_cfg_t       cfg_out,
    output logic                        cfg_valid,
    input  wire                         cfg_ready
);

    csr_cfg_pkg::typed_word_t word;
    csr_cfg_pkg::csr_cfg_t    pkt;
    logic                     pkt_valid;

    // --------------------
    // Pipeline
    // --------------------
    csr_cfg_decode #(
        .seq_base(seq_base)
    ) u_decode (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_in                    (resp_in),
        .word                       (word)
    );

    csr_cfg_execute u_execute (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .word                       (word),
        .pkt                        (pkt),
        .pkt_valid                  (pkt_valid)
    );

    // Finished packets wait here for the consumer
    csr_cfg_result u_result (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .pkt                        (pkt),
        .pkt_valid                  (pkt_valid),
        .cfg_out                    (cfg_out),
        .cfg_valid                  (cfg_valid),
        .cfg_ready                  (cfg_ready)
    );

endmodule : csr_cfg_top

`default_nettype wire

/* csr_cfg_assert.sv */
// CSR config result checks: output hold under stall, FIFO overflow and reset state
`timescale 1ns/100ps
`default_nettype none

module csr_cfg_assert (
    input wire                        ap_clk,
    input wire                        areset_csr_index_generator,
    input wire                        pkt_valid,
    input wire                        full,
    input wire csr_cfg_pkg::csr_cfg_t cfg_out,
    input wire                        cfg_valid,
    input wire                        cfg_ready
);

    // --------------------
    // Output handshake
    // --------------------
    // A stalled packet stays offered and unchanged
    property p_stall_hold;
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
            (cfg_valid && !cfg_ready) |=> (cfg_valid && $stable(cfg_out));
    endproperty

    a_stall_hold : assert property (p_stall_hold)
        else $error("cfg_out or cfg_valid changed while the consumer stalled");

    // Finished packet arriving at a full FIFO would be lost
    property p_no_overflow;
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
            !(pkt_valid && full);
    endproperty

    a_no_overflow : assert property (p_no_overflow)
        else $error("packet pushed into a full output FIFO");

    // Empty FIFO right after reset
    property p_reset_empty;
        @(posedge ap_clk) areset_csr_index_generator |=> !cfg_valid;
    endproperty

    a_reset_empty : assert property (p_reset_empty)
        else $error("cfg_valid high in the cycle after reset");

endmodule : csr_cfg_assert

`default_nettype wire

/* tb_csr_cfg.sv */
// CSR config stage testbench: drives response sequences and checks the packet stream
`timescale 1ns/100ps
`default_nettype none
`include "csr_cfg_config.svh"

module tb_csr_cfg;

    localparam int seq_base   = 16;
    localparam int chk_w      = $bits(csr_cfg_pkg::csr_cfg_t);
    localparam int wait_limit = 400;

    localparam logic [1:0] ready_low  = 2'd0;
    localparam logic [1:0] ready_high = 2'd1;
    localparam logic [1:0] ready_rand = 2'd2;

    logic                   ap_clk;
    logic                   areset_csr_index_generator;
    csr_cfg_pkg::mem_resp_t resp_in;
    csr_cfg_pkg::csr_cfg_t  cfg_out;
    logic                   cfg_valid;
    logic                   cfg_ready;

    csr_cfg_pkg::csr_cfg_t  exp_q [$];
    csr_cfg_pkg::csr_cfg_t  last_exp;
    logic [31:0]            words [`CSR_SEQ_LEN];
    logic [31:0]            data_lfsr;
    logic [1:0]             ready_mode;
    int                     errors;
    int                     n_checked;

    csr_cfg_top #(
        .seq_base(seq_base)
    ) u_dut (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_in                    (resp_in),
        .cfg_out                    (cfg_out),
        .cfg_valid                  (cfg_valid),
        .cfg_ready                  (cfg_ready)
    );

    bind csr_cfg_result csr_cfg_assert u_assert (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .pkt_valid                  (pkt_valid),
        .full                       (full),
        .cfg_out                    (cfg_out),
        .cfg_valid                  (cfg_valid),
        .cfg_ready                  (cfg_ready)
    );

    initial begin : clock_gen
        ap_clk = 1'b0;
        forever begin
            #20;
            ap_clk = ~ap_clk;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    // Galois LFSR stepped once per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            v = {v[30:0], data_lfsr[0]};
        end
    endtask

    task automatic fill_words();
        for (int i = 0; i < `CSR_SEQ_LEN; i++) begin
            take_bits(32, words[i]);
        end
    endtask

    // Expected packet from the field map of words 0 to 7
    function automatic csr_cfg_pkg::csr_cfg_t build_expected(
        input csr_cfg_pkg::csr_cfg_t prev,
        input logic [31:0]           w [`CSR_SEQ_LEN]
    );
        csr_cfg_pkg::csr_cfg_t p;
        p                 = prev;
        p.increment       = w[0][0];
        p.decrement       = w[0][1];
        p.mode_sequence   = w[0][2];
        p.mode_buffer     = w[0][3];
        p.mode_break      = w[0][4];
        p.index_start     = w[1];
        p.index_end       = w[2];
        p.stride          = w[3];
        p.granularity     = w[4][4:0];
        p.direction       = w[4][31];
        p.shift_amount    = w[4][4:0];
        p.shift_direction = w[4][31];
        p.cmd             = csr_cfg_pkg::cmd_e'(w[5][2:0]);
        p.id_module       = w[5][4:3];
        p.id_engine       = w[5][6:5];
        p.id_channel      = w[5][8:7];
        p.id_cu           = w[6][1:0];
        p.id_bundle       = w[6][3:2];
        p.id_lane         = w[6][5:4];
        p.id_buffer       = w[6][8:6];
        p.array_size      = w[7];
        return p;
    endfunction

    task automatic abort_run();
        errors++;
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [chk_w-1:0] got,
                               input logic [chk_w-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_resp(input logic valid, input int offset, input logic [31:0] data);
        @(posedge ap_clk);
        #2;
        resp_in.valid  = valid;
        resp_in.offset = `CSR_OFFSET_W'(offset);
        resp_in.data   = data;
    endtask

    task automatic send_sequence(input logic gaps);
        logic [31:0] r;
        for (int i = 0; i < `CSR_SEQ_LEN; i++) begin
            if (gaps) begin
                take_bits(2, r);
                repeat (r[1:0]) drive_resp(1'b0, 0, 32'h0);
            end
            drive_resp(1'b1, seq_base + i, words[i]);
        end
        drive_resp(1'b0, 0, 32'h0);
        last_exp = build_expected(last_exp, words);
        exp_q.push_back(last_exp);
    endtask

    task automatic wait_queue_at_most(input int level, input string what);
        int cycles;
        cycles = 0;
        while (exp_q.size() > level) begin
            @(posedge ap_clk);
            cycles++;
            if (cycles > wait_limit) begin
                $display("Timeout while waiting for %s", what);
                abort_run();
            end
        end
    endtask

    // --------------------
    // Consumer ready and comparison
    // --------------------
    // Mode is taken mid-cycle, away from the edges where the stimulus changes it
    initial begin : ready_drive
        logic [1:0]  mode_now;
        logic [31:0] ready_lfsr;
        ready_lfsr = 32'h375f;
        forever begin
            @(negedge ap_clk);
            mode_now = ready_mode;
            @(posedge ap_clk);
            #2;
            if (mode_now == ready_low) begin
                cfg_ready = 1'b0;
            end else if (mode_now == ready_high) begin
                cfg_ready = 1'b1;
            end else begin
                ready_lfsr = lfsr_step(ready_lfsr);
                cfg_ready  = ready_lfsr[0];
            end
        end
    end

    // Sampled mid-cycle for the transfer at the next rising edge
    initial begin : compare_packets
        csr_cfg_pkg::csr_cfg_t expected;
        forever begin
            @(negedge ap_clk);
            if (!areset_csr_index_generator && cfg_valid && cfg_ready) begin
                if (exp_q.size() == 0) begin
                    $display("DUT delivered a packet when none was expected");
                    abort_run();
                end
                expected = exp_q.pop_front();
                check_value("cfg_out", chk_w'(cfg_out), chk_w'(expected));
                n_checked++;
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin : stimulus
        areset_csr_index_generator = 1'b1;
        resp_in    = '0;
        cfg_ready  = 1'b1;
        ready_mode = ready_high;
        data_lfsr  = 32'h375f;
        errors     = 0;
        n_checked  = 0;
        last_exp   = '0;
        repeat (2) @(posedge ap_clk);
        #2;
        areset_csr_index_generator = 1'b0;

        fill_words();
        send_sequence(1'b0);
        wait_queue_at_most(0, "the first packet");

        // Stray words outside the window
        drive_resp(1'b1, 0, 32'hdead_0001);
        drive_resp(1'b1, seq_base - 1, 32'hdead_0002);
        drive_resp(1'b1, seq_base + `CSR_SEQ_LEN, 32'hdead_0003);
        drive_resp(1'b1, 1000, 32'hdead_0004);
        // Enough off-start words to finish a packet if any of them started a sequence
        for (int i = 0; i < `CSR_SEQ_LEN; i++) begin
            drive_resp(1'b1, seq_base + 1 + (i % (`CSR_SEQ_LEN - 1)), 32'hdead_0100 + i);
        end
        repeat (8) drive_resp(1'b0, 0, 32'h0);
        check_value("cfg_valid", chk_w'(cfg_valid), chk_w'(1'b0));
        fill_words();
        send_sequence(1'b0);
        wait_queue_at_most(0, "the packet after stray words");

        fill_words();
        send_sequence(1'b1);
        wait_queue_at_most(0, "the packet with gaps");

        // Consumer stalled across three sequences
        ready_mode = ready_low;
        repeat (3) begin
            fill_words();
            send_sequence(1'b0);
        end
        repeat (6) drive_resp(1'b0, 0, 32'h0);
        check_value("queued packets", chk_w'(exp_q.size()), chk_w'(3));
        check_value("cfg_valid", chk_w'(cfg_valid), chk_w'(1'b1));
        ready_mode = ready_high;
        wait_queue_at_most(0, "the stalled packets");

        // Only some words change
        take_bits(32, words[1]);
        take_bits(32, words[4]);
        take_bits(32, words[6]);
        send_sequence(1'b0);
        wait_queue_at_most(0, "the partly changed packet");

        ready_mode = ready_rand;
        repeat (10) begin
            wait_queue_at_most(`CSR_FIFO_DEPTH - 1, "room in the output FIFO");
            fill_words();
            send_sequence(1'b0);
        end
        wait_queue_at_most(0, "the random ready packets");
        ready_mode = ready_high;
        check_value("packet count", chk_w'(n_checked), chk_w'(17));

        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule : tb_csr_cfg

`default_nettype wire

/* vlog.f */
+incdir+.
csr_cfg_pkg.sv
csr_cfg_decode.sv
csr_cfg_execute.sv
csr_cfg_result.sv
csr_cfg_top.sv
csr_cfg_assert.sv
tb_csr_cfg.sv

/* Makefile */
TOP := tb_csr_cfg

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log
